// ==== dispatch.f ====
+incdir+tests
common/dispatchPkg.sv
dispatch/branchMaskUpdate.sv
dispatch/spaceCheck.sv
dispatch/backEndPacker.sv
dispatch/renameDispatchLatch.sv
dispatch/dispatchStage.sv
tests/dispatchTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --assert -j 0
TOP ?= dispatchTb
FILELIST ?= dispatch.f
OBJDIR ?= obj_dir

SIM := $(OBJDIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)

// ==== tests/dispatchVectors.svh ====
// dispatch stage vectors
// one row per clock cycle, expected outputs are for that same cycle

`ifndef DISPATCH_VECTORS_SVH
`define DISPATCH_VECTORS_SVH

// columns: test, offer, load lanes, store lanes, load cnt, store cnt,
// issue cnt, active cnt, verify, verify id, recover, exp valid, exp stall, exp ready
task automatic fillTable();
  // ********************
  // empty back end
  // ********************
  addRow(0, 1, 'b0101, 'b1010, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
  addRow(0, 0, 'b0000, 'b0000, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1);

  // ********************
  // capacity stalls
  // ********************
  // two loads against the load queue
  addRow(1, 1, 'b0011, 'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
  // offer while stalled is not taken
  addRow(1, 1, 'b1111, 'b0000, 15, 0, 0, 0, 0, 0, 0, 0, 1, 0);
  addRow(1, 0, 'b0000, 'b0000, 14, 0, 0, 0, 0, 0, 0, 1, 0, 1);
  // two stores against the store queue
  addRow(1, 1, 'b0000, 'b1100, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
  addRow(1, 0, 'b0000, 'b0000, 0, 15, 0, 0, 0, 0, 0, 0, 1, 0);
  addRow(1, 0, 'b0000, 'b0000, 0, 14, 0, 0, 0, 0, 0, 1, 0, 1);
  // issue queue, count at the limit still fits
  addRow(1, 1, 'b0001, 'b0010, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
  addRow(1, 0, 'b0000, 'b0000, 0, 0, 29, 0, 0, 0, 0, 0, 1, 0);
  addRow(1, 0, 'b0000, 'b0000, 0, 0, 28, 0, 0, 0, 0, 1, 0, 1);
  // active list
  addRow(1, 1, 'b1000, 'b0100, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
  addRow(1, 0, 'b0000, 'b0000, 0, 0, 0, 61, 0, 0, 0, 0, 1, 0);
  addRow(1, 0, 'b0000, 'b0000, 0, 0, 0, 60, 0, 0, 0, 1, 0, 1);

  // ********************
  // verify during stall
  // ********************
  addRow(2, 1, 'b0110, 'b1001, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
  addRow(2, 0, 'b0000, 'b0000, 0, 0, 29, 0, 1, 2, 0, 0, 1, 0);
  // bit 2 stays cleared with no verify
  addRow(2, 0, 'b0000, 'b0000, 0, 0, 29, 0, 0, 0, 0, 0, 1, 0);
  addRow(2, 0, 'b0000, 'b0000, 0, 0, 0, 0, 1, 5, 0, 1, 0, 1);

  // ********************
  // recovery flush
  // ********************
  addRow(3, 1, 'b0001, 'b0100, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
  addRow(3, 0, 'b0000, 'b0000, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
  addRow(3, 0, 'b0000, 'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);

  // ********************
  // back to back
  // ********************
  addRow(4, 1, 'b1001, 'b0110, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
  addRow(4, 1, 'b0011, 'b1100, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1);
  addRow(4, 1, 'b0100, 'b0001, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1);
  addRow(4, 0, 'b0000, 'b0000, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1);
  addRow(4, 0, 'b0000, 'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
endtask

`endif

// ==== tests/dispatchTb.sv ====
// dispatch stage testbench
// applies a table of bundles, occupancy counts and branch events and
// checks the handshake outputs and every lane of the three packet outputs

`timescale 1ns/100ps

module dispatchTb;

  import dispatchPkg::*;

  typedef struct packed {
    logic [2:0] testId;
    logic offer;
    logic [3:0] loadFlags;
    logic [3:0] storeFlags;
    logic [lsqCntWidth-1:0] ldCnt;
    logic [lsqCntWidth-1:0] stCnt;
    logic [issueQCntWidth-1:0] iqCnt;
    logic [activeListCntWidth-1:0] alCnt;
    logic vfyEn;
    logic [checkpointsLog-1:0] vfyId;
    logic recover;
    logic expValid;
    logic expStall;
    logic expReady;
  } vecRowT;

  logic clk;
  logic rstN;
  logic renameValid;
  logic renameReady;
  logic flagRecover;
  logic ctrlVerified;
  logic [checkpointsLog-1:0] ctrlVerifiedId;
  logic [lsqCntWidth-1:0] loadQueueCnt;
  logic [lsqCntWidth-1:0] storeQueueCnt;
  logic [issueQCntWidth-1:0] issueQueueCnt;
  logic [activeListCntWidth-1:0] activeListCnt;
  logic dispatchValid;
  logic stallBackEnd;
  renamedInstT renameBundle [dispatchWidth];
  issueQPacketT issueQPacket [dispatchWidth];
  activeListPacketT activeListPacket [dispatchWidth];
  lsqPacketT lsqPacket [dispatchWidth];

  vecRowT vecTable [$];
  string testNames [5];
  renamedInstT offerBundle [dispatchWidth];
  // reference copy of the bundle the latch should hold
  renamedInstT modelBundle [dispatchWidth];
  logic modelValid;
  int errCount;
  int testErrs;
  int testsRun;
  int testFails;
  int cycleCount;
  int cycleLimit = 0;

  dispatchStage dut (
    .clk               (clk),
    .rstN_i            (rstN),
    .renameValid_i     (renameValid),
    .renameBundle_i    (renameBundle),
    .renameReady_o     (renameReady),
    .flagRecover_i     (flagRecover),
    .ctrlVerified_i    (ctrlVerified),
    .ctrlVerifiedId_i  (ctrlVerifiedId),
    .loadQueueCnt_i    (loadQueueCnt),
    .storeQueueCnt_i   (storeQueueCnt),
    .issueQueueCnt_i   (issueQueueCnt),
    .activeListCnt_i   (activeListCnt),
    .dispatchValid_o   (dispatchValid),
    .stallBackEnd_o    (stallBackEnd),
    .issueQPacket_o    (issueQPacket),
    .activeListPacket_o(activeListPacket),
    .lsqPacket_o       (lsqPacket)
  );

  always #5 clk = ~clk;

  // ********************
  // run limit
  // ********************
  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("timeout: the table did not finish within %0d cycles", cycleLimit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic addRow(input int testId, offer, ldFlags, stFlags, ldCnt, stCnt,
                        iqCnt, alCnt, vfyEn, vfyId, recover, expValid, expStall,
                        expReady);
    vecRowT r;
    r.testId = 3'(testId);
    r.offer = 1'(offer);
    r.loadFlags = 4'(ldFlags);
    r.storeFlags = 4'(stFlags);
    r.ldCnt = lsqCntWidth'(ldCnt);
    r.stCnt = lsqCntWidth'(stCnt);
    r.iqCnt = issueQCntWidth'(iqCnt);
    r.alCnt = activeListCntWidth'(alCnt);
    r.vfyEn = 1'(vfyEn);
    r.vfyId = checkpointsLog'(vfyId);
    r.recover = 1'(recover);
    r.expValid = 1'(expValid);
    r.expStall = 1'(expStall);
    r.expReady = 1'(expReady);
    vecTable.push_back(r);
  endtask

  `include "dispatchVectors.svh"

  // random pc and registers, flags from the table
  task automatic randomBundle(input logic [3:0] ldFlags, input logic [3:0] stFlags);
    for (int lane = 0; lane < dispatchWidth; lane++) begin
      offerBundle[lane].pc = $urandom;
      offerBundle[lane].opcode = opcodeWidth'($urandom);
      offerBundle[lane].isLoad = ldFlags[lane];
      offerBundle[lane].isStore = stFlags[lane];
      offerBundle[lane].logDest = logRegLog'($urandom);
      offerBundle[lane].physDest = physRegLog'($urandom);
      offerBundle[lane].prevPhysDest = physRegLog'($urandom);
      offerBundle[lane].physSrc1 = physRegLog'($urandom);
      offerBundle[lane].physSrc2 = physRegLog'($urandom);
      offerBundle[lane].checkpointId = checkpointsLog'($urandom);
      // checkpoints 2 and 5 stay set for the verify rows
      offerBundle[lane].branchMask = branchMaskT'($urandom) | 8'b0010_0100;
    end
  endtask

  task automatic applyRow(input vecRowT r);
    if (r.offer) begin
      randomBundle(r.loadFlags, r.storeFlags);
      renameBundle = offerBundle;
    end
    renameValid = r.offer;
    loadQueueCnt = r.ldCnt;
    storeQueueCnt = r.stCnt;
    issueQueueCnt = r.iqCnt;
    activeListCnt = r.alCnt;
    ctrlVerified = r.vfyEn;
    ctrlVerifiedId = r.vfyId;
    flagRecover = r.recover;
  endtask

  task automatic reportMismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errCount++;
    testErrs++;
  endtask

  function automatic branchMaskT expectedMask(input branchMaskT held, input vecRowT r);
    branchMaskT cleared;
    cleared = r.vfyEn ? (branchMaskT'(1) << r.vfyId) : '0;
    return held & ~cleared;
  endfunction

  // ********************
  // output checks
  // ********************
  task automatic checkRow(input vecRowT r);
    renamedInstT m;
    branchMaskT expMask;
    issueQPacketT expIq;
    activeListPacketT expAl;
    lsqPacketT expLsq;
    assert (dispatchValid === r.expValid) else
      reportMismatch($sformatf("dispatchValid_o %b, expected %b", dispatchValid, r.expValid));
    assert (stallBackEnd === r.expStall) else
      reportMismatch($sformatf("stallBackEnd_o %b, expected %b", stallBackEnd, r.expStall));
    assert (renameReady === r.expReady) else
      reportMismatch($sformatf("renameReady_o %b, expected %b", renameReady, r.expReady));
    if (modelValid) begin
      for (int lane = 0; lane < dispatchWidth; lane++) begin
        m = modelBundle[lane];
        expMask = expectedMask(m.branchMask, r);
        expIq = '{opcode: m.opcode, physSrc1: m.physSrc1, physSrc2: m.physSrc2,
                  physDest: m.physDest, pc: m.pc, isLoad: m.isLoad, isStore: m.isStore,
                  checkpointId: m.checkpointId, branchMask: expMask};
        expAl = '{isLoad: m.isLoad, isStore: m.isStore, pc: m.pc, logDest: m.logDest,
                  physDest: m.physDest, prevPhysDest: m.prevPhysDest};
        expLsq = '{branchMask: expMask, isStore: m.isStore, isLoad: m.isLoad};
        assert (issueQPacket[lane] === expIq) else
          reportMismatch($sformatf("lane %0d issue queue packet %h, expected %h",
                                   lane, issueQPacket[lane], expIq));
        assert (activeListPacket[lane] === expAl) else
          reportMismatch($sformatf("lane %0d active list packet %h, expected %h",
                                   lane, activeListPacket[lane], expAl));
        assert (lsqPacket[lane] === expLsq) else
          reportMismatch($sformatf("lane %0d lsq packet %h, expected %h",
                                   lane, lsqPacket[lane], expLsq));
      end
    end
  endtask

  // what the latch holds after the coming edge
  task automatic updateModel(input vecRowT r);
    if (r.recover) begin
      modelValid = 1'b0;
    end else if (r.offer && r.expReady) begin
      modelBundle = offerBundle;
      modelValid = 1'b1;
    end else if (r.expValid) begin
      modelValid = 1'b0;
    end else if (modelValid) begin
      for (int lane = 0; lane < dispatchWidth; lane++) begin
        modelBundle[lane].branchMask = expectedMask(modelBundle[lane].branchMask, r);
      end
    end
  endtask

  task automatic reportTest(input int id);
    testsRun++;
    if (testErrs == 0) begin
      $display("test %0d (%s): passed", id, testNames[id]);
    end else begin
      $display("test %0d (%s): failed with %0d errors", id, testNames[id], testErrs);
      testFails++;
    end
    testErrs = 0;
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    renameValid = 1'b0;
    flagRecover = 1'b0;
    ctrlVerified = 1'b0;
    ctrlVerifiedId = '0;
    loadQueueCnt = '0;
    storeQueueCnt = '0;
    issueQueueCnt = '0;
    activeListCnt = '0;
    modelValid = 1'b0;
    errCount = 0;
    testErrs = 0;
    testsRun = 0;
    testFails = 0;
    cycleCount = 0;
    testNames = '{"empty back end", "capacity stalls", "verify during stall",
                  "recovery flush", "back to back"};
    void'($urandom(48));
    randomBundle(4'b0000, 4'b0000);
    renameBundle = offerBundle;
    fillTable();
    cycleLimit = vecTable.size() * 4 + 20;
    repeat (3) @(posedge clk);
    #1 rstN = 1'b1;
    for (int i = 0; i < vecTable.size(); i++) begin
      @(posedge clk);
      #1;
      applyRow(vecTable[i]);
      #5;
      checkRow(vecTable[i]);
      updateModel(vecTable[i]);
      if (i == vecTable.size() - 1 || vecTable[i + 1].testId != vecTable[i].testId) begin
        reportTest(vecTable[i].testId);
      end
    end
    $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testFails, errCount);
    if (errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== dispatch/dispatchStage.sv ====
// dispatch stage top
// holds one renamed four-wide bundle, checks back-end room and
// sends issue queue, active list and load-store queue packets

`timescale 1ns/100ps

module dispatchStage (
  input  logic clk,
  input  logic rstN_i,

  // rename side
  input  logic renameValid_i,
  input  dispatchPkg::renamedInstT renameBundle_i [dispatchPkg::dispatchWidth],
  output logic renameReady_o,

  // branch unit
  input  logic flagRecover_i,
  input  logic ctrlVerified_i,
  input  logic [dispatchPkg::checkpointsLog-1:0] ctrlVerifiedId_i,

  // back-end occupancy
  input  logic [dispatchPkg::lsqCntWidth-1:0] loadQueueCnt_i,
  input  logic [dispatchPkg::lsqCntWidth-1:0] storeQueueCnt_i,
  input  logic [dispatchPkg::issueQCntWidth-1:0] issueQueueCnt_i,
  input  logic [dispatchPkg::activeListCntWidth-1:0] activeListCnt_i,

  // back-end packets
  output logic dispatchValid_o,
  output logic stallBackEnd_o,
  output dispatchPkg::issueQPacketT issueQPacket_o [dispatchPkg::dispatchWidth],
  output dispatchPkg::activeListPacketT activeListPacket_o [dispatchPkg::dispatchWidth],
  output dispatchPkg::lsqPacketT lsqPacket_o [dispatchPkg::dispatchWidth]
);

  import dispatchPkg::*;

  logic heldValid;
  renamedInstT heldBundle [dispatchWidth];
  branchMaskT heldMask [dispatchWidth];
  branchMaskT updatedMask [dispatchWidth];
  logic spaceOk;
  logic dispatchFire;

  // held bundle leaves when there is room and no recovery
  assign dispatchFire = heldValid & spaceOk & ~flagRecover_i;
  assign dispatchValid_o = dispatchFire;
  assign stallBackEnd_o = heldValid & ~spaceOk;

  for (genvar lane = 0; lane < dispatchWidth; lane++) begin : genMask
    assign heldMask[lane] = heldBundle[lane].branchMask;
  end

  renameDispatchLatch latch (
    .clk           (clk),
    .rstN_i        (rstN_i),
    .bundleValid_i (renameValid_i),
    .bundle_i      (renameBundle_i),
    .updatedMask_i (updatedMask),
    .dispatchFire_i(dispatchFire),
    .flush_i       (flagRecover_i),
    .bundleReady_o (renameReady_o),
    .heldValid_o   (heldValid),
    .heldBundle_o  (heldBundle)
  );

  branchMaskUpdate maskUpdate (
    .maskIn_i        (heldMask),
    .ctrlVerified_i  (ctrlVerified_i),
    .ctrlVerifiedId_i(ctrlVerifiedId_i),
    .maskOut_o       (updatedMask)
  );

  spaceCheck space (
    .bundle_i       (heldBundle),
    .loadQueueCnt_i (loadQueueCnt_i),
    .storeQueueCnt_i(storeQueueCnt_i),
    .issueQueueCnt_i(issueQueueCnt_i),
    .activeListCnt_i(activeListCnt_i),
    .spaceOk_o      (spaceOk)
  );

  backEndPacker packer (
    .bundle_i          (heldBundle),
    .mask_i            (updatedMask),
    .issueQPacket_o    (issueQPacket_o),
    .activeListPacket_o(activeListPacket_o),
    .lsqPacket_o       (lsqPacket_o)
  );

endmodule

// ==== dispatch/renameDispatchLatch.sv ====
// rename to dispatch latch
// holds one waiting bundle and its valid flag, runs the rename-side
// valid/ready handshake and keeps the waiting branch masks current

`timescale 1ns/100ps

module renameDispatchLatch (
  input  logic clk,
  input  logic rstN_i,

  input  logic bundleValid_i,
  input  dispatchPkg::renamedInstT bundle_i [dispatchPkg::dispatchWidth],
  input  dispatchPkg::branchMaskT updatedMask_i [dispatchPkg::dispatchWidth],
  input  logic dispatchFire_i,
  input  logic flush_i,

  output logic bundleReady_o,
  output logic heldValid_o,
  output dispatchPkg::renamedInstT heldBundle_o [dispatchPkg::dispatchWidth]
);

  import dispatchPkg::*;

  logic heldValid;
  renamedInstT heldBundle [dispatchWidth];
  logic bundleReady;
  logic bundleLoad;

  // ********************
  // handshake
  // ********************
  // room when empty or when the held bundle leaves this cycle
  assign bundleReady = (~heldValid | dispatchFire_i) & ~flush_i;
  assign bundleLoad = bundleValid_i & bundleReady;

  assign bundleReady_o = bundleReady;
  assign heldValid_o = heldValid;
  assign heldBundle_o = heldBundle;

  // ********************
  // valid flag
  // ********************
  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      heldValid <= 1'b0;
    end else if (flush_i) begin
      // recovery drops whatever is waiting
      heldValid <= 1'b0;
    end else if (bundleLoad) begin
      heldValid <= 1'b1;
    end else if (dispatchFire_i) begin
      heldValid <= 1'b0;
    end
  end

  // ********************
  // bundle payload
  // ********************
  always_ff @(posedge clk) begin
    if (bundleLoad) begin
      // new bundle taken exactly as rename sent it
      heldBundle <= bundle_i;
    end else if (heldValid) begin
      // waiting bundle picks up resolved checkpoints
      for (int lane = 0; lane < dispatchWidth; lane++) begin
        heldBundle[lane].branchMask <= updatedMask_i[lane];
      end
    end
  end

endmodule

// ==== dispatch/backEndPacker.sv ====
// back-end packer
// splits each lane of the held bundle into issue queue, active list
// and load-store queue packets with the current branch mask

`timescale 1ns/100ps

module backEndPacker (
  input  dispatchPkg::renamedInstT bundle_i [dispatchPkg::dispatchWidth],
  input  dispatchPkg::branchMaskT mask_i [dispatchPkg::dispatchWidth],
  output dispatchPkg::issueQPacketT issueQPacket_o [dispatchPkg::dispatchWidth],
  output dispatchPkg::activeListPacketT activeListPacket_o [dispatchPkg::dispatchWidth],
  output dispatchPkg::lsqPacketT lsqPacket_o [dispatchPkg::dispatchWidth]
);

  import dispatchPkg::*;

  // ********************
  // issue queue
  // ********************
  always_comb begin
    for (int lane = 0; lane < dispatchWidth; lane++) begin
      issueQPacket_o[lane].opcode = bundle_i[lane].opcode;
      issueQPacket_o[lane].physSrc1 = bundle_i[lane].physSrc1;
      issueQPacket_o[lane].physSrc2 = bundle_i[lane].physSrc2;
      issueQPacket_o[lane].physDest = bundle_i[lane].physDest;
      issueQPacket_o[lane].pc = bundle_i[lane].pc;
      issueQPacket_o[lane].isLoad = bundle_i[lane].isLoad;
      issueQPacket_o[lane].isStore = bundle_i[lane].isStore;
      issueQPacket_o[lane].checkpointId = bundle_i[lane].checkpointId;
      // updated mask, not the one stored in the latch
      issueQPacket_o[lane].branchMask = mask_i[lane];
    end
  end

  // ********************
  // active list
  // ********************
  always_comb begin
    for (int lane = 0; lane < dispatchWidth; lane++) begin
      activeListPacket_o[lane].isLoad = bundle_i[lane].isLoad;
      activeListPacket_o[lane].isStore = bundle_i[lane].isStore;
      activeListPacket_o[lane].pc = bundle_i[lane].pc;
      activeListPacket_o[lane].logDest = bundle_i[lane].logDest;
      activeListPacket_o[lane].physDest = bundle_i[lane].physDest;
      // freed at retirement
      activeListPacket_o[lane].prevPhysDest = bundle_i[lane].prevPhysDest;
    end
  end

  // ********************
  // load-store queue
  // ********************
  always_comb begin
    for (int lane = 0; lane < dispatchWidth; lane++) begin
      lsqPacket_o[lane].branchMask = mask_i[lane];
      lsqPacket_o[lane].isStore = bundle_i[lane].isStore;
      lsqPacket_o[lane].isLoad = bundle_i[lane].isLoad;
    end
  end

endmodule

// ==== dispatch/spaceCheck.sv ====
// back-end space check
// counts loads and stores in the held bundle and tests the load queue,
// store queue, issue queue and active list for room

`timescale 1ns/100ps

module spaceCheck (
  input  dispatchPkg::renamedInstT bundle_i [dispatchPkg::dispatchWidth],
  input  logic [dispatchPkg::lsqCntWidth-1:0] loadQueueCnt_i,
  input  logic [dispatchPkg::lsqCntWidth-1:0] storeQueueCnt_i,
  input  logic [dispatchPkg::issueQCntWidth-1:0] issueQueueCnt_i,
  input  logic [dispatchPkg::activeListCntWidth-1:0] activeListCnt_i,
  output logic spaceOk_o
);

  import dispatchPkg::*;

  logic [lsqCntWidth-1:0] loadCnt;
  logic [lsqCntWidth-1:0] storeCnt;

  // one extra bit so the sums cannot wrap
  logic [lsqCntWidth:0] loadSum;
  logic [lsqCntWidth:0] storeSum;
  logic [issueQCntWidth:0] issueSum;
  logic [activeListCntWidth:0] activeSum;

  // ********************
  // load/store count
  // ********************
  always_comb begin
    loadCnt = '0;
    storeCnt = '0;
    for (int lane = 0; lane < dispatchWidth; lane++) begin
      loadCnt = loadCnt + lsqCntWidth'(bundle_i[lane].isLoad);
      storeCnt = storeCnt + lsqCntWidth'(bundle_i[lane].isStore);
    end
  end

  // ********************
  // capacity rules
  // ********************
  assign loadSum = {1'b0, loadQueueCnt_i} + {1'b0, loadCnt};
  assign storeSum = {1'b0, storeQueueCnt_i} + {1'b0, storeCnt};
  // every lane takes an issue queue and active list slot
  assign issueSum = {1'b0, issueQueueCnt_i} + (issueQCntWidth + 1)'(dispatchWidth);
  assign activeSum = {1'b0, activeListCnt_i} + (activeListCntWidth + 1)'(dispatchWidth);

  assign spaceOk_o = (loadSum <= sizeLsq) &&
                     (storeSum <= sizeLsq) &&
                     (issueSum <= sizeIssueQ) &&
                     (activeSum <= sizeActiveList);

endmodule

// ==== dispatch/branchMaskUpdate.sv ====
// branch mask update
// clears the checkpoint bit of a correctly resolved branch in
// every lane's branch mask

`timescale 1ns/100ps

module branchMaskUpdate (
  input  dispatchPkg::branchMaskT maskIn_i [dispatchPkg::dispatchWidth],
  input  logic ctrlVerified_i,
  input  logic [dispatchPkg::checkpointsLog-1:0] ctrlVerifiedId_i,
  output dispatchPkg::branchMaskT maskOut_o [dispatchPkg::dispatchWidth]
);

  import dispatchPkg::*;

  branchMaskT clearMask;

  // one-hot of the verified checkpoint, zero when nothing verifies
  always_comb begin
    clearMask = '0;
    if (ctrlVerified_i) begin
      clearMask[ctrlVerifiedId_i] = 1'b1;
    end
  end

  // other bits pass through untouched
  always_comb begin
    for (int lane = 0; lane < dispatchWidth; lane++) begin
      maskOut_o[lane] = maskIn_i[lane] & ~clearMask;
    end
  end

endmodule

// ==== common/dispatchPkg.sv ====
// dispatch package
// widths, back-end capacities and packet types shared by the
// four-wide dispatch stage

package dispatchPkg;

  // ********************
  // machine shape
  // ********************
  localparam int dispatchWidth = 4;
  localparam int checkpoints = 8;
  localparam int checkpointsLog = 3;

  localparam int physRegLog = 7;
  localparam int logRegLog = 5;
  localparam int pcWidth = 32;
  localparam int opcodeWidth = 8;

  // ********************
  // back-end capacities
  // ********************
  // load and store queues are the same size
  localparam int sizeLsq = 16;
  localparam int sizeIssueQ = 32;
  localparam int sizeActiveList = 64;

  // occupancy counts run 0..size inclusive
  localparam int lsqCntWidth = 5;
  localparam int issueQCntWidth = 6;
  localparam int activeListCntWidth = 7;

  // one bit per unresolved branch checkpoint
  typedef logic [checkpoints-1:0] branchMaskT;

  // renamed instruction as it leaves rename
  typedef struct packed {
    logic [pcWidth-1:0] pc;
    logic [opcodeWidth-1:0] opcode;
    logic isLoad;
    logic isStore;
    logic [logRegLog-1:0] logDest;
    logic [physRegLog-1:0] physDest;
    logic [physRegLog-1:0] prevPhysDest;
    logic [physRegLog-1:0] physSrc1;
    logic [physRegLog-1:0] physSrc2;
    logic [checkpointsLog-1:0] checkpointId;
    branchMaskT branchMask;
  } renamedInstT;

  // scheduler view of an instruction
  typedef struct packed {
    logic [opcodeWidth-1:0] opcode;
    logic [physRegLog-1:0] physSrc1;
    logic [physRegLog-1:0] physSrc2;
    logic [physRegLog-1:0] physDest;
    logic [pcWidth-1:0] pc;
    logic isLoad;
    logic isStore;
    logic [checkpointsLog-1:0] checkpointId;
    branchMaskT branchMask;
  } issueQPacketT;

  // retirement bookkeeping
  typedef struct packed {
    logic isLoad;
    logic isStore;
    logic [pcWidth-1:0] pc;
    logic [logRegLog-1:0] logDest;
    logic [physRegLog-1:0] physDest;
    logic [physRegLog-1:0] prevPhysDest;
  } activeListPacketT;

  // memory ordering entry, flags in the low bits
  typedef struct packed {
    branchMaskT branchMask;
    logic isStore;
    logic isLoad;
  } lsqPacketT;

endpackage
